// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_eeprom_wr
FLIST     ?= verilog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output"
	@echo "variables: VERILATOR TOP FLIST OBJ_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) -Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "^TEST PASSED$$"

clean:
	rm -rf $(OBJ_DIR)

// ==== sim/eeprom_patterns.txt ====
# op (w write, r read, b wr and rd together), address hex, data hex, expected nack
# on reads the data column is the byte expected back
w 012 a5 0
w 112 3c 0
w 612 c3 0
w 2f0 5a 0
w 4ff 81 0
r 012 a5 0
r 112 3c 0
r 612 c3 0
r 2f0 5a 0
w 712 77 1
r 712 00 1
r 4ff 81 0
b 2f0 e7 0
r 2f0 e7 0
w 3a0 11 0
w 3a0 22 0
r 3a0 22 0
r 712 00 1

// ==== sim/eeprom_protocol_checker.sv ====
`timescale 1ns/1ns
module eeprom_protocol_checker import eeprom_pkg::*;
(
    input logic        CLK,
    input logic        RESET,
    input logic        ack,
    input logic        nack,
    input logic        scl,
    input logic        sda,
    input ctrl_state_t state
);
    assert property (@(posedge CLK) disable iff (RESET) !(ack && nack))
        else $error("ack and nack high together");
    assert property (@(posedge CLK) disable iff (RESET) ack |=> !ack)
        else $error("ack longer than one cycle");
    assert property (@(posedge CLK) disable iff (RESET) nack |=> !nack)
        else $error("nack longer than one cycle");
    assert property (@(posedge CLK) disable iff (RESET) (state == IDLE) |-> scl)
        else $error("scl low while idle");
    // sda may only move under a high scl for start or stop
    assert property (@(posedge CLK) disable iff (RESET)
        (scl && $past(scl) && $changed(sda)) |-> (state inside {START, RESTART, STOP}))
        else $error("sda changed with scl high in state %s", state.name());
endmodule

bind eeprom_wr eeprom_protocol_checker chk (
    .CLK   (CLK),
    .RESET (RESET),
    .ack   (ack),
    .nack  (nack),
    .scl   (scl),
    .sda   (sda),
    .state (u_fsm.state)
);

// ==== sim/eeprom_scoreboard.sv ====
`timescale 1ns/1ns
module eeprom_scoreboard import eeprom_pkg::*;
(
    input  logic     CLK,
    input  logic     RESET,
    input  logic     ack,
    input  logic     nack,
    input  ee_byte_t rd_data,
    input  int       exp_seq,
    input  logic     exp_is_rd,
    input  logic     exp_nack,
    input  ee_byte_t exp_data,
    input  int       slave_stops,
    output int       errors,
    output int       resp_count
);
    ee_byte_t last_rd;   // value rd_data must hold until the next good read
    logic     have_last;

    initial
    begin
        errors = 0;
        resp_count = 0;
        have_last = 1'b0;
        last_rd = '0;
    end

    always @(negedge CLK)
    begin
        if (!RESET && (ack || nack))
        begin
            resp_count = resp_count + 1;
            if (resp_count > exp_seq)
            begin
                errors = errors + 1;
                $display("completion pulse at %0t without an accepted request", $time);
            end
            if (ack !== !exp_nack)
            begin
                errors = errors + 1;
                $display("MISMATCH time=%0t signal=ack expected=%0b actual=%0b",
                         $time, !exp_nack, ack);
            end
            if (nack !== exp_nack)
            begin
                errors = errors + 1;
                $display("MISMATCH time=%0t signal=nack expected=%0b actual=%0b",
                         $time, exp_nack, nack);
            end
            if (slave_stops != resp_count)
            begin
                errors = errors + 1;
                $display("MISMATCH time=%0t signal=slave_stops expected=%0d actual=%0d",
                         $time, resp_count, slave_stops);
            end
            if (exp_is_rd && !exp_nack)
            begin
                if (rd_data !== exp_data)
                begin
                    errors = errors + 1;
                    $display("MISMATCH time=%0t signal=rd_data expected=%h actual=%h",
                             $time, exp_data, rd_data);
                end
                last_rd = exp_data;
                have_last = 1'b1;
            end
            else if (have_last && rd_data !== last_rd)
            begin
                errors = errors + 1;
                $display("MISMATCH time=%0t signal=rd_data expected=%h actual=%h",
                         $time, last_rd, rd_data);
            end
        end
    end

endmodule

// ==== sim/eeprom_slave_model.sv ====
`timescale 1ns/1ns
module eeprom_slave_model
(
    input  logic scl,
    inout  wire  sda,
    output int   stop_count
);
    logic [7:0]  mem [0:2047];
    logic        sda_low;
    logic        scl_q;
    logic        sda_q;
    logic        active;
    logic        armed;       // first fall after a start is not a bit
    logic        tx;
    logic        read_next;
    logic        acked;
    int          bit_cnt;
    int          byte_idx;
    logic [7:0]  shift;
    logic [7:0]  tx_byte;
    logic [2:0]  blk;
    logic [10:0] ptr;

    pullup (sda);
    assign sda = sda_low ? 1'b0 : 1'bz;

    initial
    begin
        for (int i = 0; i < 2048; i++)
            mem[i] = 8'(i) ^ 8'(i >> 3);
        sda_low = 1'b0;
        scl_q = 1'b1;
        sda_q = 1'b1;
        active = 1'b0;
        armed = 1'b0;
        tx = 1'b0;
        read_next = 1'b0;
        bit_cnt = 0;
        byte_idx = 0;
        stop_count = 0;
    end

    always @(scl or sda)
    begin
        if (scl && scl_q && sda_q && !sda)
        begin
            // start or repeated start
            active = 1'b1;
            armed = 1'b0;
            tx = 1'b0;
            read_next = 1'b0;
            bit_cnt = 0;
            byte_idx = 0;
            sda_low = 1'b0;
        end
        else if (scl && scl_q && !sda_q && sda)
        begin
            active = 1'b0;
            sda_low = 1'b0;
            stop_count = stop_count + 1;
        end
        else if (active && scl && !scl_q)
        begin
            if (bit_cnt < 8 && !tx)
                shift = {shift[6:0], sda};
        end
        else if (active && !scl && scl_q)
        begin
            if (!armed)
                armed = 1'b1;
            else if (bit_cnt < 7)
            begin
                bit_cnt = bit_cnt + 1;
                if (tx)
                    sda_low = ~tx_byte[7 - bit_cnt];
            end
            else if (bit_cnt == 7)
            begin
                bit_cnt = 8;
                if (tx)
                    sda_low = 1'b0;  // master answers here
                else
                begin
                    case (byte_idx)
                        0:
                        begin
                            blk = shift[3:1];
                            acked = (shift[7:4] == 4'b1010) && (blk != 3'd7); // block 7 absent
                            read_next = shift[0];
                        end
                        1:
                        begin
                            ptr = {blk, shift};
                            acked = 1'b1;
                        end
                        2:
                        begin
                            mem[ptr] = shift;
                            acked = 1'b1;
                        end
                        default: acked = 1'b0;
                    endcase
                    byte_idx = byte_idx + 1;
                    sda_low = acked;
                    if (!acked)
                        active = 1'b0;
                end
            end
            else
            begin
                bit_cnt = 0;
                sda_low = 1'b0;
                if (tx)
                begin
                    tx = 1'b0;
                    active = 1'b0;
                end
                else if (read_next)
                begin
                    tx = 1'b1;
                    tx_byte = mem[ptr];
                    sda_low = ~tx_byte[7];
                end
            end
        end
        scl_q = scl;
        sda_q = sda;
    end

endmodule

// ==== sim/tb_eeprom_wr.sv ====
`timescale 1ns/1ns
module tb_eeprom_wr;
    import eeprom_pkg::*;

    logic        CLK;
    logic        RESET;
    logic        wr;
    logic        rd;
    ee_addr_t    addr;
    ee_byte_t    wr_data;
    ee_byte_t    rd_data;
    logic        ack;
    logic        nack;
    logic        scl;
    wire         sda;
    int          exp_seq;
    logic        exp_is_rd;
    logic        exp_nack;
    ee_byte_t    exp_data;
    int          slave_stops;
    int          sb_errors;
    int          resp_count;
    int          tb_errors;
    int unsigned seed;

    eeprom_wr #(.CLKS_PER_QUARTER(4)) dut (
        .CLK(CLK), .RESET(RESET), .wr(wr), .rd(rd), .addr(addr), .wr_data(wr_data),
        .rd_data(rd_data), .ack(ack), .nack(nack), .scl(scl), .sda(sda)
    );

    eeprom_slave_model slave (.scl(scl), .sda(sda), .stop_count(slave_stops));

    eeprom_scoreboard sb (
        .CLK(CLK), .RESET(RESET), .ack(ack), .nack(nack), .rd_data(rd_data),
        .exp_seq(exp_seq), .exp_is_rd(exp_is_rd), .exp_nack(exp_nack),
        .exp_data(exp_data), .slave_stops(slave_stops), .errors(sb_errors),
        .resp_count(resp_count)
    );

    initial
    begin
        CLK = 1'b0;
        forever #50 CLK = ~CLK;
    end

    function automatic int unsigned lcg_next();
        seed = seed * 32'd1103515245 + 32'd12345;
        return seed;
    endfunction

    task automatic wait_response(output bit ok);
        int n;
        n = 0;
        ok = 1'b0;
        while (!ok && n < 2000)
        begin
            @(negedge CLK);
            ok = ack || nack;
            n++;
        end
    endtask

    // one accepted strobe, then a stray one while busy
    task automatic run_one(input byte op, input ee_addr_t a, input ee_byte_t d,
                           input logic en, output bit ok);
        @(posedge CLK);
        #10;
        wr = (op == "w") || (op == "b");
        rd = (op == "r") || (op == "b");
        addr = a;
        wr_data = d;
        exp_is_rd = (op == "r");
        exp_nack = en;
        exp_data = d;
        exp_seq++;
        @(posedge CLK);
        #10;
        wr = 1'b0;
        rd = 1'b0;
        repeat (2) @(posedge CLK);
        #10;
        rd = 1'b1;
        @(posedge CLK);
        #10;
        rd = 1'b0;
        wait_response(ok);
        if (!ok)
        begin
            tb_errors++;
            $display("no ack or nack within 2000 cycles for op %s at address %h", op, a);
        end
    endtask

    initial
    begin
        int       fd;
        int       cnt;
        string    line;
        byte      op;
        ee_addr_t a;
        ee_byte_t d;
        logic     en;
        bit       ok;
        RESET = 1'b1;
        wr = 1'b0;
        rd = 1'b0;
        addr = '0;
        wr_data = '0;
        exp_seq = 0;
        exp_is_rd = 1'b0;
        exp_nack = 1'b0;
        exp_data = '0;
        tb_errors = 0;
        seed = 66;
        ok = 1'b1;
        repeat (5) @(posedge CLK);
        #10;
        RESET = 1'b0;
        fd = $fopen("sim/eeprom_patterns.txt", "r");
        if (fd == 0)
        begin
            tb_errors++;
            $display("cannot open sim/eeprom_patterns.txt");
        end
        else
        begin
            while (ok && $fgets(line, fd))
            begin
                cnt = $sscanf(line, "%c %h %h %h", op, a, d, en);
                if (cnt == 4 && op != "#")
                begin
                    run_one(op, a, d, en, ok);
                    repeat (1 + (lcg_next() >> 16) % 8) @(posedge CLK);
                end
            end
            $fclose(fd);
        end
        repeat (4) @(posedge CLK);
        $display("closing: %0d transactions, %0d responses, scoreboard errors %0d, tb errors %0d",
                 exp_seq, resp_count, sb_errors, tb_errors);
        if (sb_errors == 0 && tb_errors == 0 && resp_count == exp_seq && exp_seq > 0)
            $display("TEST PASSED");
        else
            $display("TEST FAILED");
        $finish;
    end

endmodule

// ==== src/eeprom_ctrl_fsm.sv ====
`timescale 1ns/1ns
module eeprom_ctrl_fsm import eeprom_pkg::*;
(
    input  logic      CLK,
    input  logic      RESET,
    input  logic      wr,
    input  logic      rd,
    input  ee_addr_t  addr,
    input  ee_byte_t  wr_data,
    input  logic      op_done,
    input  logic      ack_bit,
    input  ee_byte_t  rx_byte,
    output line_cmd_t cmd,
    output logic      run,
    output ee_byte_t  rd_data,
    output logic      ack,
    output logic      nack
);
    ctrl_state_t state;
    ee_addr_t    addr_q;
    ee_byte_t    data_q;
    ee_byte_t    rd_buf;
    ee_blk_t     blk;
    logic        is_rd;
    logic        fail;
    logic        tx_state;

    assign blk      = addr_q[10:8];
    assign tx_state = (state == CTRL_W) || (state == ADDR_W) || (state == DATA_W)
                      || (state == CTRL_R);

    function automatic line_cmd_t issue(input line_op_t op, input ee_byte_t tx,
                                        input logic last);
        line_cmd_t c;
        c.go      = 1'b1;
        c.op      = op;
        c.tx_byte = tx;
        c.last_rx = last;
        return c;
    endfunction

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            state <= IDLE;
            cmd   <= '0;
            run   <= 1'b0;
            ack   <= 1'b0;
            nack  <= 1'b0;
            is_rd <= 1'b0;
            fail  <= 1'b0;
        end
        else
        begin
            cmd.go <= 1'b0;
            if (op_done && ack_bit && tx_state)
            begin
                // no ack from the slave, wrap up with a stop
                fail  <= 1'b1;
                cmd   <= issue(OP_STOP, '0, 1'b0);
                state <= STOP;
            end
            else
            begin
                case (state)
                    IDLE:
                        if (wr || rd)
                        begin
                            is_rd <= !wr;   // write wins
                            fail  <= 1'b0;
                            run   <= 1'b1;
                            cmd   <= issue(OP_START, '0, 1'b0);
                            state <= START;
                        end
                    START:
                        if (op_done)
                        begin
                            cmd   <= issue(OP_TX, {CTRL_DEVICE, blk, 1'b0}, 1'b0);
                            state <= CTRL_W;
                        end
                    CTRL_W:
                        if (op_done)
                        begin
                            cmd   <= issue(OP_TX, addr_q[7:0], 1'b0);
                            state <= ADDR_W;
                        end
                    ADDR_W:
                        if (op_done && is_rd)
                        begin
                            cmd   <= issue(OP_START, '0, 1'b0); // repeated start
                            state <= RESTART;
                        end
                        else if (op_done)
                        begin
                            cmd   <= issue(OP_TX, data_q, 1'b0);
                            state <= DATA_W;
                        end
                    RESTART:
                        if (op_done)
                        begin
                            cmd   <= issue(OP_TX, {CTRL_DEVICE, blk, 1'b1}, 1'b0);
                            state <= CTRL_R;
                        end
                    CTRL_R:
                        if (op_done)
                        begin
                            cmd   <= issue(OP_RX, '0, 1'b1);  // single byte, nack it
                            state <= DATA_R;
                        end
                    DATA_W, DATA_R:
                        if (op_done)
                        begin
                            cmd   <= issue(OP_STOP, '0, 1'b0);
                            state <= STOP;
                        end
                    STOP:
                        if (op_done)
                        begin
                            run   <= 1'b0;
                            ack   <= !fail;
                            nack  <= fail;
                            state <= DONE;
                        end
                    DONE:
                    begin
                        ack   <= 1'b0;
                        nack  <= 1'b0;
                        state <= IDLE;
                    end
                    default: state <= IDLE;
                endcase
            end
        end
    end

    // request operands and read result
    always_ff @(posedge CLK)
    begin
        if (state == IDLE && (wr || rd))
        begin
            addr_q <= addr;
            data_q <= wr_data;
        end
        if (state == DATA_R && op_done)
            rd_buf <= rx_byte;
        if (state == STOP && op_done && is_rd && !fail)
            rd_data <= rd_buf;   // same edge as ack
    end

endmodule

// ==== src/eeprom_pkg.sv ====
package eeprom_pkg;

    typedef logic [10:0] ee_addr_t;   // 2 KB word address
    typedef logic [7:0]  ee_byte_t;
    typedef logic [2:0]  ee_blk_t;    // addr[10:8], lands in the control byte

    // control byte is {CTRL_DEVICE, block, r/w}
    localparam logic [3:0] CTRL_DEVICE = 4'b1010;

    // scl low in the first two quarters, high in the last two
    typedef enum logic [1:0] {
        PH_LOW_SET,
        PH_LOW_HOLD,
        PH_HIGH_SAMPLE,
        PH_HIGH_HOLD
    } slot_phase_t;

    typedef struct packed {
        logic        tick;   // strobe at the start of each quarter
        slot_phase_t phase;
    } scl_slot_t;

    typedef enum logic [1:0] {OP_START, OP_STOP, OP_TX, OP_RX} line_op_t;

    typedef struct packed {
        logic     go;
        line_op_t op;
        ee_byte_t tx_byte;
        logic     last_rx;   // master nack after the received byte
    } line_cmd_t;

    typedef enum logic [3:0] {
        IDLE, START, CTRL_W, ADDR_W, DATA_W, RESTART, CTRL_R, DATA_R, STOP, DONE
    } ctrl_state_t;

endpackage

// ==== src/eeprom_wr.sv ====
`timescale 1ns/1ns
module eeprom_wr import eeprom_pkg::*;
#(
    parameter int CLKS_PER_QUARTER = 4   // 3 or more, shifter needs go before the next tick
)
(
    input  logic     CLK,
    input  logic     RESET,
    input  logic     wr,
    input  logic     rd,
    input  ee_addr_t addr,
    input  ee_byte_t wr_data,
    output ee_byte_t rd_data,
    output logic     ack,
    output logic     nack,
    output logic     scl,
    inout  wire      sda
);
    scl_slot_t slot;
    line_cmd_t cmd;
    logic      run;
    logic      op_done;
    logic      ack_bit;
    ee_byte_t  rx_byte;

    scl_timer #(
        .CLKS_PER_QUARTER(CLKS_PER_QUARTER)
    ) u_timer (
        .CLK   (CLK),
        .RESET (RESET),
        .run   (run),
        .slot  (slot),
        .scl   (scl)
    );

    sda_shifter u_shifter (
        .CLK     (CLK),
        .RESET   (RESET),
        .slot    (slot),
        .cmd     (cmd),
        .sda     (sda),
        .rx_byte (rx_byte),
        .op_done (op_done),
        .ack_bit (ack_bit)
    );

    eeprom_ctrl_fsm u_fsm (
        .CLK     (CLK),
        .RESET   (RESET),
        .wr      (wr),
        .rd      (rd),
        .addr    (addr),
        .wr_data (wr_data),
        .op_done (op_done),
        .ack_bit (ack_bit),
        .rx_byte (rx_byte),
        .cmd     (cmd),
        .run     (run),
        .rd_data (rd_data),
        .ack     (ack),
        .nack    (nack)
    );

endmodule

// ==== src/scl_timer.sv ====
`timescale 1ns/1ns
module scl_timer import eeprom_pkg::*;
#(
    parameter int CLKS_PER_QUARTER = 4
)
(
    input  logic      CLK,
    input  logic      RESET,
    input  logic      run,
    output scl_slot_t slot,
    output logic      scl
);
    localparam int PW = (CLKS_PER_QUARTER > 1) ? $clog2(CLKS_PER_QUARTER) : 1;

    logic [PW-1:0] pre_cnt;

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            pre_cnt    <= '0;
            slot.tick  <= 1'b0;
            slot.phase <= PH_HIGH_HOLD;
        end
        else if (!run)
        begin
            // parked, bus idles with scl high
            pre_cnt    <= '0;
            slot.tick  <= 1'b0;
            slot.phase <= PH_HIGH_HOLD;
        end
        else if (pre_cnt == PW'(CLKS_PER_QUARTER - 1))
        begin
            pre_cnt    <= '0;
            slot.tick  <= 1'b1;
            slot.phase <= slot_phase_t'(slot.phase + 2'd1); // wraps to low-set
        end
        else
        begin
            pre_cnt   <= pre_cnt + 1'b1;
            slot.tick <= 1'b0;
        end
    end

    assign scl = (slot.phase == PH_HIGH_SAMPLE) || (slot.phase == PH_HIGH_HOLD);

endmodule

// ==== src/sda_shifter.sv ====
`timescale 1ns/1ns
module sda_shifter import eeprom_pkg::*;
(
    input  logic      CLK,
    input  logic      RESET,
    input  scl_slot_t slot,
    input  line_cmd_t cmd,
    inout  wire       sda,
    output ee_byte_t  rx_byte,
    output logic      op_done,
    output logic      ack_bit
);
    logic       busy;
    line_op_t   op_q;
    ee_byte_t   shift_q;
    logic       last_q;
    logic [3:0] slot_cnt;
    logic       sda_oe;     // open drain, high means pull low
    logic       last_slot;
    logic       data_slot;

    assign sda       = sda_oe ? 1'b0 : 1'bz;
    assign rx_byte   = shift_q;
    assign data_slot = (slot_cnt < 4'd8);
    assign last_slot = (op_q == OP_START || op_q == OP_STOP) ? 1'b1 : (slot_cnt == 4'd8);

    // line control, reacts one clock after each quarter tick
    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            busy     <= 1'b0;
            op_q     <= OP_START;
            slot_cnt <= 4'd0;
            sda_oe   <= 1'b0;
            op_done  <= 1'b0;
            ack_bit  <= 1'b0;
        end
        else
        begin
            op_done <= 1'b0;
            if (cmd.go && !busy)
            begin
                busy     <= 1'b1;
                op_q     <= cmd.op;
                slot_cnt <= 4'd0;
            end
            else if (busy && slot.tick)
            begin
                case (slot.phase)
                    PH_LOW_SET:
                        case (op_q)
                            OP_START: sda_oe <= 1'b0;
                            OP_STOP:  sda_oe <= 1'b1;
                            OP_TX:    sda_oe <= data_slot ? ~shift_q[7] : 1'b0;
                            default:  sda_oe <= data_slot ? 1'b0 : ~last_q; // rx ack slot
                        endcase
                    PH_HIGH_SAMPLE:
                        if (op_q == OP_TX && last_slot)
                            ack_bit <= sda;  // low means slave acked
                    PH_HIGH_HOLD:
                    begin
                        if (op_q == OP_START)
                            sda_oe <= 1'b1;   // sda falls, scl high
                        else if (op_q == OP_STOP)
                            sda_oe <= 1'b0;   // sda rises, scl high
                        if (last_slot)
                        begin
                            busy    <= 1'b0;
                            op_done <= 1'b1;
                        end
                        else
                            slot_cnt <= slot_cnt + 4'd1;
                    end
                    default: ;
                endcase
            end
        end
    end

    // data path, msb first both ways
    always_ff @(posedge CLK)
    begin
        if (cmd.go && !busy)
        begin
            shift_q <= cmd.tx_byte;
            last_q  <= cmd.last_rx;
        end
        else if (busy && slot.tick && data_slot)
        begin
            if (op_q == OP_TX && slot.phase == PH_LOW_SET)
                shift_q <= {shift_q[6:0], 1'b0};
            else if (op_q == OP_RX && slot.phase == PH_HIGH_SAMPLE)
                shift_q <= {shift_q[6:0], sda};
        end
    end

endmodule

// ==== verilog.f ====
src/eeprom_pkg.sv
src/scl_timer.sv
src/sda_shifter.sv
src/eeprom_ctrl_fsm.sv
src/eeprom_wr.sv
sim/eeprom_slave_model.sv
sim/eeprom_scoreboard.sv
sim/eeprom_protocol_checker.sv
sim/tb_eeprom_wr.sv
